//--- hw/oflow_pkg.sv
/*
 * optical-flow tracker, overlap cost path
 * shared coordinate, box, area and cost types plus the
 * field layout of a packed bounding box
 */
package oflow_pkg;

	// ------------------------------
	// frame coordinates
	// ------------------------------
	localparam int COORD_W = 11;                   // covers a 2048 pixel frame
	typedef logic [COORD_W-1:0] coord_t;

	// ------------------------------
	// packed box {x_tl, y_tl, x_br, y_br}
	// ------------------------------
	localparam int BBOX_W = 4 * COORD_W;
	typedef logic [BBOX_W-1:0] bbox_t;

	// low bit of each field, x_tl sits on top
	localparam int Y_BR_POS = 0;
	localparam int X_BR_POS = Y_BR_POS + COORD_W;
	localparam int Y_TL_POS = X_BR_POS + COORD_W;
	localparam int X_TL_POS = Y_TL_POS + COORD_W;

	// ------------------------------
	// areas
	// ------------------------------
	// product of two extents
	localparam int AREA_W = 2 * COORD_W;
	typedef logic [AREA_W-1:0] area_t;

	// sum of two areas needs one carry bit
	typedef logic [AREA_W:0] area_sum_t;

	// ------------------------------
	// cost
	// ------------------------------
	// fraction of one, 16 bits
	localparam int IOU_W = 16;
	typedef logic [IOU_W-1:0] iou_t;

	localparam iou_t IOU_FULL = '1;                // cost of no overlap at all

	// quotient reaches 65536 for identical boxes, so one bit above IOU_W
	localparam int DIV_STEPS = IOU_W + 1;

endpackage

//--- hw/oflow_bbox_overlap.sv
/*
 * bbox overlap stage
 * clips two boxes against each other and registers the
 * area of their intersection, zero when they do not overlap
 */
`timescale 1ns/100ps

module oflow_bbox_overlap (
	input  logic             clk,
	input  logic             reset_N,
	input  logic             load,
	input  oflow_pkg::bbox_t box_a,
	input  oflow_pkg::bbox_t box_b,
	output oflow_pkg::area_t inter_area,
	output logic             inter_valid
);

	localparam int CW = oflow_pkg::COORD_W;

	// box corners
	oflow_pkg::coord_t a_x_tl, a_y_tl, a_x_br, a_y_br;
	oflow_pkg::coord_t b_x_tl, b_y_tl, b_x_br, b_y_br;

	// intersection corners
	oflow_pkg::coord_t ix_tl, iy_tl, ix_br, iy_br;
	oflow_pkg::coord_t ext_x, ext_y;
	oflow_pkg::area_t  inter_next;
	logic              empty;

	function automatic oflow_pkg::coord_t cmax(input oflow_pkg::coord_t a,
		input oflow_pkg::coord_t b);
		return (a > b) ? a : b;
	endfunction

	function automatic oflow_pkg::coord_t cmin(input oflow_pkg::coord_t a,
		input oflow_pkg::coord_t b);
		return (a < b) ? a : b;
	endfunction

	// ------------------------------
	// field split
	// ------------------------------
	assign a_x_tl = box_a[oflow_pkg::X_TL_POS +: CW];
	assign a_y_tl = box_a[oflow_pkg::Y_TL_POS +: CW];
	assign a_x_br = box_a[oflow_pkg::X_BR_POS +: CW];
	assign a_y_br = box_a[oflow_pkg::Y_BR_POS +: CW];
	assign b_x_tl = box_b[oflow_pkg::X_TL_POS +: CW];
	assign b_y_tl = box_b[oflow_pkg::Y_TL_POS +: CW];
	assign b_x_br = box_b[oflow_pkg::X_BR_POS +: CW];
	assign b_y_br = box_b[oflow_pkg::Y_BR_POS +: CW];

	// ------------------------------
	// clipping
	// ------------------------------
	assign ix_tl = cmax(a_x_tl, b_x_tl);           // inner left edge
	assign iy_tl = cmax(a_y_tl, b_y_tl);           // inner top edge
	assign ix_br = cmin(a_x_br, b_x_br);
	assign iy_br = cmin(a_y_br, b_y_br);

	// touching edges count as no overlap
	assign empty = (ix_br <= ix_tl) || (iy_br <= iy_tl);

	assign ext_x      = ix_br - ix_tl;             // only meaningful when !empty
	assign ext_y      = iy_br - iy_tl;
	assign inter_next = ext_x * ext_y;             // 22 bit context

	always_ff @(posedge clk) begin
		if (load)
			inter_area <= empty ? '0 : inter_next;
	end

	always_ff @(posedge clk, posedge reset_N) begin
		if (reset_N)
			inter_valid <= 1'b0;
		else
			inter_valid <= load;                   // one cycle behind load
	end

endmodule

//--- hw/oflow_bbox_area.sv
/*
 * bbox area stage
 * derives width and height of both boxes from their corners
 * and registers the sum of the two areas
 */
`timescale 1ns/100ps

module oflow_bbox_area (
	input  logic                 clk,
	input  logic                 reset_N,
	input  logic                 load,
	input  oflow_pkg::bbox_t     box_a,
	input  oflow_pkg::bbox_t     box_b,
	output oflow_pkg::area_sum_t area_sum,
	output logic                 area_valid
);

	localparam int CW = oflow_pkg::COORD_W;

	oflow_pkg::area_t     area_a;
	oflow_pkg::area_t     area_b;
	oflow_pkg::area_sum_t sum_next;

	// edge length, clamped at zero for flipped corners
	function automatic oflow_pkg::coord_t extent(input oflow_pkg::coord_t lo,
		input oflow_pkg::coord_t hi);
		return (hi > lo) ? hi - lo : '0;
	endfunction

	// width times height of one packed box
	function automatic oflow_pkg::area_t box_area(input oflow_pkg::bbox_t b);
		oflow_pkg::coord_t w;
		oflow_pkg::coord_t h;
		oflow_pkg::area_t  a;
		w = extent(b[oflow_pkg::X_TL_POS +: CW], b[oflow_pkg::X_BR_POS +: CW]);
		h = extent(b[oflow_pkg::Y_TL_POS +: CW], b[oflow_pkg::Y_BR_POS +: CW]);
		a = w * h;                                 // widened to area width
		return a;
	endfunction

	// ------------------------------
	// areas
	// ------------------------------
	assign area_a = box_area(box_a);
	assign area_b = box_area(box_b);

	// carry bit kept
	assign sum_next = oflow_pkg::area_sum_t'(area_a) + oflow_pkg::area_sum_t'(area_b);

	always_ff @(posedge clk) begin
		if (load)
			area_sum <= sum_next;
	end

	// same cycle as the overlap stage
	always_ff @(posedge clk, posedge reset_N) begin
		if (reset_N)
			area_valid <= 1'b0;
		else
			area_valid <= load;
	end

endmodule

//--- hw/oflow_iou_divider.sv
/*
 * iou divider
 * forms the union, divides the scaled intersection by it with a
 * restoring divider and outputs the cost as one minus the ratio
 */
`timescale 1ns/100ps

module oflow_iou_divider (
	input  logic                 clk,
	input  logic                 reset_N,
	input  logic                 start,
	input  oflow_pkg::area_t     inter_area,
	input  oflow_pkg::area_sum_t area_sum,
	output logic                 valid_iou,
	output oflow_pkg::iou_t      iou
);

	localparam int IW    = oflow_pkg::IOU_W;
	localparam int STEPS = oflow_pkg::DIV_STEPS;
	localparam int NUM_W = $bits(oflow_pkg::area_t) + IW;      // intersection << 16
	localparam int DEN_W = $bits(oflow_pkg::area_sum_t) + IW;  // union << 16
	localparam int CNT_W = $clog2(STEPS);

	typedef enum logic [1:0] {
		idle,
		divide,
		finish
	} div_state_t;

	div_state_t state;

	logic [CNT_W-1:0] step_q;                      // divide step index
	logic [NUM_W-1:0] rem_q;                       // partial remainder
	logic [DEN_W-1:0] den_q;                       // shifted union
	logic [STEPS-1:0] quo_q;
	logic             zero_union_q;

	oflow_pkg::area_sum_t union_area;
	oflow_pkg::iou_t      ratio;
	oflow_pkg::iou_t      cost;
	logic                 take;

	// ------------------------------
	// union and compare
	// ------------------------------
	assign union_area = area_sum - oflow_pkg::area_sum_t'(inter_area);

	// remainder covers the shifted union, quotient bit is one
	assign take = {1'b0, rem_q} >= den_q;

	// 65536 only for equal boxes, clip to full scale
	assign ratio = quo_q[STEPS-1] ? oflow_pkg::IOU_FULL : quo_q[IW-1:0];
	assign cost  = oflow_pkg::IOU_FULL - ratio;

	// ------------------------------
	// control FSM
	// ------------------------------
	always_ff @(posedge clk, posedge reset_N) begin
		if (reset_N) begin
			state     <= idle;
			step_q    <= '0;
			valid_iou <= 1'b0;
			iou       <= '0;
		end else begin
			valid_iou <= 1'b0;                     // pulse by default
			case (state)
				idle: begin
					if (start) begin
						state  <= divide;
						step_q <= '0;
					end
				end
				divide: begin
					step_q <= step_q + 1'b1;
					if (step_q == CNT_W'(STEPS - 1))
						state <= finish;           // last quotient bit this cycle
				end
				finish: begin
					// empty union, nothing to match
					iou       <= zero_union_q ? oflow_pkg::IOU_FULL : cost;
					valid_iou <= 1'b1;
					state     <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// ------------------------------
	// datapath, msb quotient bit first
	// ------------------------------
	always_ff @(posedge clk) begin
		if (state == idle && start) begin
			rem_q        <= {inter_area, {IW{1'b0}}};
			den_q        <= {union_area, {IW{1'b0}}};
			quo_q        <= '0;
			zero_union_q <= (union_area == '0);
		end else if (state == divide) begin
			if (take)
				rem_q <= rem_q - den_q[NUM_W-1:0]; // den fits when take is set
			den_q <= den_q >> 1;
			quo_q <= {quo_q[STEPS-2:0], take};
		end
	end

endmodule

//--- hw/oflow_calc_iou.sv
/*
 * overlap cost top
 * captures a detection box and a history box on start and returns
 * one minus their iou after a fixed latency of 21 cycles
 */
`timescale 1ns/100ps

module oflow_calc_iou (
	input  logic             clk,
	input  logic             reset_N,
	input  logic             start,
	input  oflow_pkg::bbox_t bbox_k,
	input  oflow_pkg::bbox_t bbox_hist,
	output logic             busy,
	output logic             valid_iou,
	output oflow_pkg::iou_t  iou
);

	logic                 accept;                  // start taken this cycle
	logic                 busy_q;
	logic                 load_q;
	oflow_pkg::bbox_t     box_k_q;
	oflow_pkg::bbox_t     box_hist_q;

	oflow_pkg::area_t     inter_area;
	logic                 inter_valid;
	oflow_pkg::area_sum_t area_sum;
	logic                 area_valid;
	logic                 div_start;

	// ------------------------------
	// capture and busy
	// ------------------------------
	// busy falls together with the result pulse
	assign busy   = busy_q & ~valid_iou;
	assign accept = start & ~busy;                 // starts in flight are dropped

	always_ff @(posedge clk) begin
		if (accept) begin
			box_k_q    <= bbox_k;
			box_hist_q <= bbox_hist;
		end
	end

	always_ff @(posedge clk, posedge reset_N) begin
		if (reset_N) begin
			busy_q <= 1'b0;
			load_q <= 1'b0;
		end else begin
			load_q <= accept;                      // stages see captured boxes
			if (accept)
				busy_q <= 1'b1;
			else if (valid_iou)
				busy_q <= 1'b0;
		end
	end

	// ------------------------------
	// stages
	// ------------------------------
	oflow_bbox_overlap oflow_bbox_overlap_i (
		.clk         (clk),
		.reset_N     (reset_N),
		.load        (load_q),
		.box_a       (box_k_q),
		.box_b       (box_hist_q),
		.inter_area  (inter_area),
		.inter_valid (inter_valid)
	);

	oflow_bbox_area oflow_bbox_area_i (
		.clk        (clk),
		.reset_N    (reset_N),
		.load       (load_q),
		.box_a      (box_k_q),
		.box_b      (box_hist_q),
		.area_sum   (area_sum),
		.area_valid (area_valid)
	);

	// both stages finish on the same cycle
	assign div_start = inter_valid & area_valid;

	oflow_iou_divider oflow_iou_divider_i (
		.clk        (clk),
		.reset_N    (reset_N),
		.start      (div_start),
		.inter_area (inter_area),
		.area_sum   (area_sum),
		.valid_iou  (valid_iou),
		.iou        (iou)
	);

endmodule

//--- tests/oflow_calc_iou_asserts.sv
/*
 * overlap cost top, strobe assertions
 * fixed start to result latency, single cycle result pulse, idle after reset
 */
`timescale 1ns/100ps

module oflow_calc_iou_asserts (
	input logic clk,
	input logic reset_N,
	input logic start,
	input logic busy,
	input logic valid_iou
);

	int assert_fails = 0;                          // read by the testbench

	// accepted start gives the result 21 cycles later
	latency_a: assert property (@(posedge clk) disable iff (reset_N)
		(start && !busy) |-> ##21 valid_iou)
		else begin
			assert_fails++;
			$error("valid_iou not 21 cycles after accepted start");
		end

	pulse_a: assert property (@(posedge clk) disable iff (reset_N)
		valid_iou |=> !valid_iou)                  // one cycle only
		else begin
			assert_fails++;
			$error("valid_iou held longer than one cycle");
		end

	busy_a: assert property (@(posedge clk) disable iff (reset_N)
		(start && !busy) |=> busy)
		else begin
			assert_fails++;
			$error("busy not raised after accepted start");
		end

	// idle during and right after reset
	reset_a: assert property (@(posedge clk)
		(reset_N || $fell(reset_N)) |-> (!busy && !valid_iou))
		else begin
			assert_fails++;
			$error("busy or valid_iou high around reset");
		end

endmodule

//--- tests/oflow_calc_iou_tb.sv
/*
 * overlap cost testbench
 * table of hand-computed box pairs, then random pairs checked
 * against a reference cost model, with latency and busy checks
 */
`timescale 1ns/100ps

module oflow_calc_iou_tb;

	localparam int CLK_PERIOD      = 8;
	localparam int LATENCY         = 21;          // start cycle to valid_iou
	localparam int NUM_TABLE       = 12;
	localparam int NUM_RANDOM      = 40;
	localparam int POKE_CYCLE      = LATENCY - 2; // second start just before the result
	localparam int QUIET_CYCLES    = 25;
	localparam int WATCHDOG_CYCLES = (NUM_TABLE + NUM_RANDOM) * 30;
	localparam int SEED            = 69321;
	localparam int CW              = oflow_pkg::COORD_W;

	logic                   clk;
	logic                   reset_N;
	logic                   start;
	oflow_pkg::bbox_t       bbox_k;
	oflow_pkg::bbox_t       bbox_hist;
	logic                   busy;
	logic                   valid_iou;
	oflow_pkg::iou_t        iou;

	// stimulus table
	oflow_pkg::bbox_t       tbl_k    [NUM_TABLE];
	oflow_pkg::bbox_t       tbl_hist [NUM_TABLE];
	oflow_pkg::iou_t        tbl_cost [NUM_TABLE];
	logic                   tbl_poke [NUM_TABLE];  // extra start while busy

	oflow_calc_iou oflow_calc_iou_i (
		.clk       (clk),
		.reset_N   (reset_N),
		.start     (start),
		.bbox_k    (bbox_k),
		.bbox_hist (bbox_hist),
		.busy      (busy),
		.valid_iou (valid_iou),
		.iou       (iou)
	);

	bind oflow_calc_iou oflow_calc_iou_asserts asserts_i (
		.clk       (clk),
		.reset_N   (reset_N),
		.start     (start),
		.busy      (busy),
		.valid_iou (valid_iou)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------
	// failure and compare
	// ------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_iou(input string name, input oflow_pkg::iou_t got,
		input oflow_pkg::iou_t exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// ------------------------------
	// boxes and reference cost
	// ------------------------------
	function automatic oflow_pkg::bbox_t pack_box(input int x_tl, input int y_tl,
		input int x_br, input int y_br);
		oflow_pkg::bbox_t b;
		b = '0;
		b[oflow_pkg::X_TL_POS +: CW] = oflow_pkg::coord_t'(x_tl);
		b[oflow_pkg::Y_TL_POS +: CW] = oflow_pkg::coord_t'(y_tl);
		b[oflow_pkg::X_BR_POS +: CW] = oflow_pkg::coord_t'(x_br);
		b[oflow_pkg::Y_BR_POS +: CW] = oflow_pkg::coord_t'(y_br);
		return b;
	endfunction

	function automatic int field(input oflow_pkg::bbox_t b, input int pos);
		return int'(b[pos +: CW]);
	endfunction

	function automatic longint span(input int lo, input int hi);
		return (hi > lo) ? longint'(hi - lo) : 64'sd0;   // negative counts as empty
	endfunction

	function automatic oflow_pkg::iou_t ref_cost(input oflow_pkg::bbox_t a,
		input oflow_pkg::bbox_t b);
		longint area_a;
		longint area_b;
		longint inter;
		longint uni;
		longint ratio;
		int     lx;
		int     ty;
		int     rx;
		int     by;
		area_a = span(field(a, oflow_pkg::X_TL_POS), field(a, oflow_pkg::X_BR_POS)) *
			span(field(a, oflow_pkg::Y_TL_POS), field(a, oflow_pkg::Y_BR_POS));
		area_b = span(field(b, oflow_pkg::X_TL_POS), field(b, oflow_pkg::X_BR_POS)) *
			span(field(b, oflow_pkg::Y_TL_POS), field(b, oflow_pkg::Y_BR_POS));
		lx = field(a, oflow_pkg::X_TL_POS);
		if (field(b, oflow_pkg::X_TL_POS) > lx) lx = field(b, oflow_pkg::X_TL_POS);
		ty = field(a, oflow_pkg::Y_TL_POS);
		if (field(b, oflow_pkg::Y_TL_POS) > ty) ty = field(b, oflow_pkg::Y_TL_POS);
		rx = field(a, oflow_pkg::X_BR_POS);
		if (field(b, oflow_pkg::X_BR_POS) < rx) rx = field(b, oflow_pkg::X_BR_POS);
		by = field(a, oflow_pkg::Y_BR_POS);
		if (field(b, oflow_pkg::Y_BR_POS) < by) by = field(b, oflow_pkg::Y_BR_POS);
		inter = span(lx, rx) * span(ty, by);
		uni   = area_a + area_b - inter;
		if (uni == 0)
			return oflow_pkg::IOU_FULL;            // nothing to compare
		ratio = (inter * 65536) / uni;
		if (ratio > 65535)
			ratio = 65535;
		return oflow_pkg::IOU_FULL - oflow_pkg::iou_t'(ratio);
	endfunction

	function automatic int clamp_coord(input int v);
		if (v < 0)
			return 0;
		if (v > 2047)
			return 2047;
		return v;
	endfunction

	// corner moved by up to 100 pixels either way
	function automatic int jitter(input int v);
		return clamp_coord(v + int'($urandom % 201) - 100);
	endfunction

	// ------------------------------
	// hand-computed table
	// ------------------------------
	task automatic load_table();
		tbl_k[0]  = pack_box(10, 10, 30, 30);     // identical
		tbl_hist[0] = pack_box(10, 10, 30, 30);
		tbl_cost[0] = 16'd0;
		tbl_k[1]  = pack_box(0, 0, 10, 10);       // disjoint
		tbl_hist[1] = pack_box(20, 20, 30, 30);
		tbl_cost[1] = 16'hffff;
		tbl_k[2]  = pack_box(0, 0, 10, 10);       // shared edge only
		tbl_hist[2] = pack_box(10, 0, 20, 10);
		tbl_cost[2] = 16'hffff;
		tbl_k[3]  = pack_box(0, 0, 10, 10);       // 50 / 150
		tbl_hist[3] = pack_box(5, 0, 15, 10);
		tbl_cost[3] = 16'd43690;
		tbl_k[4]  = pack_box(0, 0, 20, 20);       // contained, 100 / 400
		tbl_hist[4] = pack_box(5, 5, 15, 15);
		tbl_cost[4] = 16'd49151;
		tbl_k[5]  = pack_box(0, 0, 10, 10);       // corner, 25 / 175
		tbl_hist[5] = pack_box(5, 5, 15, 15);
		tbl_cost[5] = 16'd56173;
		tbl_k[6]  = pack_box(10, 10, 10, 30);     // zero width
		tbl_hist[6] = pack_box(0, 0, 20, 40);
		tbl_cost[6] = 16'hffff;
		tbl_k[7]  = pack_box(30, 10, 10, 30);     // br left of tl
		tbl_hist[7] = pack_box(0, 0, 40, 40);
		tbl_cost[7] = 16'hffff;
		tbl_k[8]  = pack_box(5, 5, 5, 5);         // zero union
		tbl_hist[8] = pack_box(7, 7, 7, 9);
		tbl_cost[8] = 16'hffff;
		tbl_k[9]  = pack_box(100, 200, 300, 260); // 6000 / 22000
		tbl_hist[9] = pack_box(150, 220, 350, 300);
		tbl_cost[9] = 16'd47662;
		tbl_k[10] = pack_box(0, 0, 2047, 2047);   // full frame vs lower half
		tbl_hist[10] = pack_box(0, 0, 2047, 1024);
		tbl_cost[10] = 16'd32751;
		tbl_k[11] = pack_box(0, 0, 3, 1000);      // thin strips, 2000 / 4000
		tbl_hist[11] = pack_box(1, 0, 4, 1000);
		tbl_cost[11] = 16'd32767;
		foreach (tbl_poke[i])
			tbl_poke[i] = 1'b0;
		tbl_poke[9] = 1'b1;
	endtask

	// ------------------------------
	// one box pair, called on a falling edge
	// ------------------------------
	task automatic run_pair(input oflow_pkg::bbox_t k, input oflow_pkg::bbox_t h,
		input oflow_pkg::iou_t exp, input logic poke);
		int n;
		start     = 1'b1;
		bbox_k    = k;
		bbox_hist = h;
		@(negedge clk);
		n         = 1;
		start     = 1'b0;
		bbox_k    = ~k;                            // captured copy must be used
		bbox_hist = ~h;
		while (!valid_iou) begin
			check_level("busy", busy, 1'b1);
			if (poke && n == POKE_CYCLE) begin
				start     = 1'b1;                  // ignored, busy is high
				bbox_k    = h;
				bbox_hist = h;
			end else begin
				start = 1'b0;
			end
			if (n > LATENCY + 8)
				abort_run("valid_iou never arrived after an accepted start");
			@(negedge clk);
			n++;
		end
		if (n != LATENCY)
			abort_run($sformatf("valid_iou came %0d cycles after start, not %0d",
				n, LATENCY));
		check_level("busy", busy, 1'b0);           // drops with the result
		check_iou("iou", iou, exp);
		@(negedge clk);
		check_level("valid_iou", valid_iou, 1'b0);
		if (poke) begin
			repeat (QUIET_CYCLES) begin
				@(negedge clk);
				check_level("valid_iou", valid_iou, 1'b0);
				check_level("busy", busy, 1'b0);
			end
			check_iou("iou", iou, exp);            // pending result kept
		end
	endtask

	// ------------------------------
	// watchdog
	// ------------------------------
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		oflow_pkg::bbox_t rk;
		oflow_pkg::bbox_t rh;
		int               x0;
		int               y0;
		reset_N   = 1'b1;                          // reset asserted
		start     = 1'b0;
		bbox_k    = '0;
		bbox_hist = '0;
		void'($urandom(SEED));
		load_table();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_N = 1'b0;
		check_level("busy", busy, 1'b0);
		check_level("valid_iou", valid_iou, 1'b0);
		check_iou("iou", iou, '0);
		@(negedge clk);

		for (int i = 0; i < NUM_TABLE; i++)
			run_pair(tbl_k[i], tbl_hist[i], tbl_cost[i], tbl_poke[i]);

		// random pairs, second box near the first
		for (int i = 0; i < NUM_RANDOM; i++) begin
			x0 = int'($urandom % 1800);
			y0 = int'($urandom % 1800);
			rk = pack_box(x0, y0, clamp_coord(x0 + int'($urandom % 300) - 20),
				clamp_coord(y0 + int'($urandom % 300) - 20));
			rh = pack_box(jitter(field(rk, oflow_pkg::X_TL_POS)),
				jitter(field(rk, oflow_pkg::Y_TL_POS)),
				jitter(field(rk, oflow_pkg::X_BR_POS)),
				jitter(field(rk, oflow_pkg::Y_BR_POS)));
			run_pair(rk, rh, ref_cost(rk, rh), 1'b0);
		end

		if (oflow_calc_iou_i.asserts_i.assert_fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("assertion failures: %0d", oflow_calc_iou_i.asserts_i.assert_fails);
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- vlog.f
hw/oflow_pkg.sv
hw/oflow_bbox_overlap.sv
hw/oflow_bbox_area.sv
hw/oflow_iou_divider.sv
hw/oflow_calc_iou.sv
tests/oflow_calc_iou_asserts.sv
tests/oflow_calc_iou_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the overlap cost testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f \
	--top-module oflow_calc_iou_tb \
	-o oflow_calc_iou_sim

# the log decides the outcome, not the exit status of the run
./obj_dir/oflow_calc_iou_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi

echo "run failed, see sim.log"
exit 1
